// File: flist.f
+incdir+include
logic/core_pkg.sv
logic/mem_bus_if.sv
logic/core_ctrl.sv
logic/core_decode.sv
logic/core_alu.sv
logic/core_regfile.sv
logic/core_lsu.sv
logic/mem_arbiter.sv
logic/serial_core_top.sv
sim/tb_core.sv

// File: logic/core_alu.sv
// Bit-serial add, subtract and boolean unit
`timescale 1ns/1ns

module core_alu (
   input  logic                       clk,
   input  core_pkg::decoded_t         i_dec,
   input  logic [core_pkg::CNT_W-1:0] i_cnt,
   input  logic                       i_rs1_bit,
   input  logic                       i_rs2_bit,
   input  logic                       i_imm_bit,
   output logic                       o_rd_bit
);
   import core_pkg::*;

   logic op_b;
   logic is_sub;
   logic b_eff;
   logic cin;
   logic sum;
   logic carry_q;

   assign op_b   = i_dec.op_b_imm ? i_imm_bit : i_rs2_bit;
   assign is_sub = (i_dec.alu_op == ALU_SUB);

   // Two's complement subtract: invert b, carry in of one on bit 0
   assign b_eff = op_b ^ is_sub;
   assign cin   = (i_cnt == '0) ? is_sub : carry_q;
   assign sum   = i_rs1_bit ^ b_eff ^ cin;

   always_ff @(posedge clk) begin
      carry_q <= (i_rs1_bit & b_eff) | (cin & (i_rs1_bit ^ b_eff));
   end

   always_comb begin
      case (i_dec.alu_op)
         ALU_AND: o_rd_bit = i_rs1_bit & op_b;
         ALU_OR:  o_rd_bit = i_rs1_bit | op_b;
         ALU_XOR: o_rd_bit = i_rs1_bit ^ op_b;
         default: o_rd_bit = sum;
      endcase
   end

endmodule

// File: logic/core_ctrl.sv
// Phase sequencer, bit counter, program counter and instruction fetch
`timescale 1ns/1ns

module core_ctrl #(
   parameter core_pkg::word_t RESET_PC = '0
) (
   input  logic                       clk,
   input  logic                       i_reset,
   input  core_pkg::decoded_t         i_dec,
   input  logic                       i_mem_done,
   output core_pkg::phase_e           o_phase,
   output logic [core_pkg::CNT_W-1:0] o_cnt,
   output logic                       o_cnt_done,
   output logic                       o_rd_wen,
   mem_bus_if.requester               ibus
);
   import core_pkg::*;

   phase_e           phase;
   logic [CNT_W-1:0] cnt;
   word_t            pc;
   logic             fetch_cyc;
   logic             is_load;
   logic             is_mem;
   logic             insn_end;

   assign is_load    = (i_dec.opcode == OPC_LOAD);
   assign is_mem     = is_load || (i_dec.opcode == OPC_STORE);
   assign o_cnt_done = &cnt;

   // Last cycle of the instruction, whichever phase finishes it
   assign insn_end = (phase == PH_EXEC && o_cnt_done && !is_mem) ||
                     (phase == PH_MEM && i_mem_done && !is_load) ||
                     (phase == PH_WB && o_cnt_done);

   always_ff @(posedge clk) begin
      if (i_reset) begin
         phase     <= PH_FETCH;
         cnt       <= '0;
         pc        <= RESET_PC;
         fetch_cyc <= 1'b0;
      end else begin
         if (phase == PH_EXEC || phase == PH_WB) begin
            cnt <= cnt + 1'b1;
         end
         case (phase)
            PH_FETCH: begin
               if (!fetch_cyc) begin
                  fetch_cyc <= 1'b1;
               end else if (ibus.ack) begin
                  fetch_cyc <= 1'b0;
                  phase     <= PH_DECODE;
               end
            end
            PH_DECODE: phase <= PH_EXEC;
            PH_EXEC: begin
               if (o_cnt_done && is_mem) begin
                  phase <= PH_MEM;
               end
            end
            PH_MEM: begin
               if (i_mem_done && is_load) begin
                  phase <= PH_WB;
               end
            end
            default: ;
         endcase
         if (insn_end) begin
            pc    <= pc + XLEN'(4);
            phase <= PH_FETCH;
         end
      end
   end

   assign o_phase  = phase;
   assign o_cnt    = cnt;
   assign o_rd_wen = (phase == PH_WB) ||
                     (phase == PH_EXEC && (i_dec.opcode == OPC_OP ||
                      i_dec.opcode == OPC_OP_IMM || i_dec.opcode == OPC_LUI));

   assign ibus.adr = pc;
   assign ibus.dat = '0;
   assign ibus.we  = 1'b0;
   assign ibus.cyc = fetch_cyc;

   // Counter only runs during serial phases
   a_cnt_phase: assert property (@(posedge clk) disable iff (i_reset)
      (cnt != '0) |-> (phase inside {PH_EXEC, PH_WB}));

endmodule

// File: logic/core_decode.sv
// Instruction latch, field decode and serial immediate generation
`timescale 1ns/1ns

module core_decode (
   input  logic                       clk,
   input  logic                       i_reset,
   input  core_pkg::word_t            ibus_rdt,
   input  logic                       ibus_ack,
   input  core_pkg::phase_e           i_phase,
   input  logic [core_pkg::CNT_W-1:0] i_cnt,
   output core_pkg::decoded_t         o_dec,
   output logic                       o_imm_bit
);
   import core_pkg::*;

   // addi x0, x0, 0
   localparam word_t NOP_INSN = 32'h0000_0013;

   word_t   ir;
   word_t   imm_word;
   opcode_e opcode;
   logic    is_alu;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         ir <= NOP_INSN;
      end else if (ibus_ack) begin
         ir <= ibus_rdt;
      end
   end

   assign opcode = opcode_e'(ir[6:0]);
   assign is_alu = (opcode == OPC_OP) || (opcode == OPC_OP_IMM);

   always_comb begin
      o_dec.opcode   = opcode;
      o_dec.rd       = ir[11:7];
      o_dec.rs1      = ir[19:15];
      o_dec.rs2      = ir[24:20];
      o_dec.op_b_imm = (opcode != OPC_OP);

      o_dec.alu_op = ALU_ADD;
      if (is_alu) begin
         case (ir[14:12])
            3'b100:  o_dec.alu_op = ALU_XOR;
            3'b110:  o_dec.alu_op = ALU_OR;
            3'b111:  o_dec.alu_op = ALU_AND;
            // funct7 bit 5 only means SUB for register forms
            default: o_dec.alu_op = (opcode == OPC_OP && ir[30]) ? ALU_SUB : ALU_ADD;
         endcase
      end

      case (opcode)
         OPC_LOAD: o_dec.rd_src = RD_MEM;
         OPC_LUI:  o_dec.rd_src = RD_IMM;
         default:  o_dec.rd_src = RD_ALU;
      endcase
   end

   // Immediate formats, sign extended from bit 31
   always_comb begin
      case (opcode)
         OPC_STORE: imm_word = {{20{ir[31]}}, ir[31:25], ir[11:7]};
         OPC_LUI:   imm_word = {ir[31:12], 12'b0};
         default:   imm_word = {{20{ir[31]}}, ir[31:20]};
      endcase
   end

   assign o_imm_bit = (i_phase == PH_EXEC) && imm_word[i_cnt];

endmodule

// File: logic/core_lsu.sv
// Load/store unit with serial address build and data shift register
`timescale 1ns/1ns

module core_lsu (
   input  logic                       clk,
   input  logic                       i_reset,
   input  core_pkg::decoded_t         i_dec,
   input  core_pkg::phase_e           i_phase,
   input  logic [core_pkg::CNT_W-1:0] i_cnt,
   input  logic                       i_rs1_bit,
   input  logic                       i_rs2_bit,
   input  logic                       i_imm_bit,
   output logic                       o_mem_bit,
   output logic                       o_mem_done,
   mem_bus_if.requester               dbus
);
   import core_pkg::*;

   word_t adr_q;
   word_t dat_q;
   logic  carry_q;
   logic  cin;
   logic  adr_bit;
   logic  is_store;
   logic  is_mem;
   logic  cyc_q;

   assign is_store = (i_dec.opcode == OPC_STORE);
   assign is_mem   = is_store || (i_dec.opcode == OPC_LOAD);

   // rs1 + imm one bit per cycle
   assign cin     = (i_cnt == '0) ? 1'b0 : carry_q;
   assign adr_bit = i_rs1_bit ^ i_imm_bit ^ cin;

   always_ff @(posedge clk) begin
      carry_q <= (i_rs1_bit & i_imm_bit) | (cin & (i_rs1_bit ^ i_imm_bit));
      if (i_phase == PH_EXEC && is_mem) begin
         adr_q <= {adr_bit, adr_q[XLEN-1:1]};
      end
      // Same register holds store data, then load data on its way to rd
      if (i_phase == PH_EXEC && is_store) begin
         dat_q <= {i_rs2_bit, dat_q[XLEN-1:1]};
      end else if (o_mem_done && !is_store) begin
         dat_q <= dbus.rdt;
      end else if (i_phase == PH_WB) begin
         dat_q <= {1'b0, dat_q[XLEN-1:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         cyc_q <= 1'b0;
      end else if (i_phase == PH_MEM && !cyc_q) begin
         cyc_q <= 1'b1;
      end else if (dbus.ack) begin
         cyc_q <= 1'b0;
      end
   end

   assign dbus.adr   = adr_q;
   assign dbus.dat   = dat_q;
   assign dbus.we    = is_store;
   assign dbus.cyc   = cyc_q;
   assign o_mem_done = cyc_q & dbus.ack;
   assign o_mem_bit  = dat_q[0];

   // A pending request holds its address and data until acknowledged
   a_req_hold: assert property (@(posedge clk) disable iff (i_reset)
      (cyc_q && !dbus.ack) |=> ($stable(adr_q) && $stable(dat_q)));

endmodule

// File: logic/core_pkg.sv
// Shared widths, encodings and decode bundle for the bit-serial core
package core_pkg;

   localparam int XLEN  = 32;
   localparam int CNT_W = 5;

   typedef logic [XLEN-1:0] word_t;
   typedef logic [4:0]      reg_addr_t;

   // RV32I major opcodes in use
   typedef enum logic [6:0] {
      OPC_OP_IMM = 7'b0010011,
      OPC_OP     = 7'b0110011,
      OPC_LOAD   = 7'b0000011,
      OPC_STORE  = 7'b0100011,
      OPC_LUI    = 7'b0110111
   } opcode_e;

   typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR} alu_op_e;

   typedef enum logic [1:0] {RD_ALU, RD_MEM, RD_IMM} rd_src_e;

   typedef enum logic [2:0] {PH_FETCH, PH_DECODE, PH_EXEC, PH_MEM, PH_WB} phase_e;

   typedef struct packed {
      opcode_e   opcode;
      alu_op_e   alu_op;
      rd_src_e   rd_src;
      logic      op_b_imm;
      reg_addr_t rd;
      reg_addr_t rs1;
      reg_addr_t rs2;
   } decoded_t;

endpackage

// File: logic/core_regfile.sv
// General purpose registers with one-bit read and write ports
`timescale 1ns/1ns

module core_regfile (
   input  logic                       clk,
   input  core_pkg::decoded_t         i_dec,
   input  logic [core_pkg::CNT_W-1:0] i_cnt,
   input  logic                       i_rd_wen,
   input  logic                       i_alu_bit,
   input  logic                       i_mem_bit,
   input  logic                       i_imm_bit,
   output logic                       o_rs1_bit,
   output logic                       o_rs2_bit
);
   import core_pkg::*;

   word_t regs [32];
   logic  wr_bit;

   // x0 is never written, so its reads are forced to zero
   assign o_rs1_bit = (i_dec.rs1 != '0) && regs[i_dec.rs1][i_cnt];
   assign o_rs2_bit = (i_dec.rs2 != '0) && regs[i_dec.rs2][i_cnt];

   always_comb begin
      case (i_dec.rd_src)
         RD_MEM:  wr_bit = i_mem_bit;
         RD_IMM:  wr_bit = i_imm_bit;
         default: wr_bit = i_alu_bit;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_rd_wen && i_dec.rd != '0) begin
         regs[i_dec.rd][i_cnt] <= wr_bit;
      end
   end

endmodule

// File: logic/mem_arbiter.sv
// Shares the memory port between instruction fetch and data access
`timescale 1ns/1ns

module mem_arbiter (
   mem_bus_if.arbiter      ibus,
   mem_bus_if.arbiter      dbus,
   output core_pkg::word_t o_mem_adr,
   output core_pkg::word_t o_mem_dat,
   output logic            o_mem_we,
   output logic            o_mem_cyc,
   input  core_pkg::word_t i_mem_rdt,
   input  logic            i_mem_ack
);
   logic dsel;

   assign dsel = dbus.cyc;

   assign o_mem_adr = dsel ? dbus.adr : ibus.adr;
   assign o_mem_dat = dsel ? dbus.dat : ibus.dat;
   assign o_mem_we  = dsel ? dbus.we : ibus.we;
   assign o_mem_cyc = ibus.cyc | dbus.cyc;

   assign ibus.rdt = i_mem_rdt;
   assign dbus.rdt = i_mem_rdt;
   assign ibus.ack = i_mem_ack & ibus.cyc;
   assign dbus.ack = i_mem_ack & dbus.cyc;

   // Phase sequencing keeps fetch and data requests apart
   a_one_active: assert property (@(posedge ibus.clk) !(ibus.cyc && dbus.cyc));

endmodule

// File: logic/mem_bus_if.sv
// Single memory request channel between a requester and the arbiter
`timescale 1ns/1ns

interface mem_bus_if (
   input logic clk
);
   import core_pkg::*;

   word_t adr;
   word_t dat;
   logic  we;
   logic  cyc;
   word_t rdt;
   logic  ack;

   modport requester (output adr, dat, we, cyc, input rdt, ack);

   // Clock is only needed on the arbiter side for its checks
   modport arbiter (input clk, adr, dat, we, cyc, output rdt, ack);

endinterface

// File: logic/serial_core_top.sv
// Bit-serial RV32I subset core with a shared memory port
`timescale 1ns/1ns

module serial_core_top #(
   parameter core_pkg::word_t RESET_PC = '0
) (
   input  logic            clk,
   input  logic            i_reset,
   output core_pkg::word_t o_mem_adr,
   output core_pkg::word_t o_mem_dat,
   output logic            o_mem_we,
   output logic            o_mem_cyc,
   input  core_pkg::word_t i_mem_rdt,
   input  logic            i_mem_ack
);
   import core_pkg::*;

   decoded_t         dec;
   phase_e           phase;
   logic [CNT_W-1:0] cnt;
   logic             rd_wen;
   logic             mem_done;
   logic             imm_bit;
   logic             rs1_bit;
   logic             rs2_bit;
   logic             alu_bit;
   logic             mem_bit;

   mem_bus_if ibus (.clk(clk));
   mem_bus_if dbus (.clk(clk));

   core_ctrl #(.RESET_PC(RESET_PC)) ctrl (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_dec      (dec),
      .i_mem_done (mem_done),
      .o_phase    (phase),
      .o_cnt      (cnt),
      .o_cnt_done (),
      .o_rd_wen   (rd_wen),
      .ibus       (ibus.requester)
   );

   core_decode decode (
      .clk       (clk),
      .i_reset   (i_reset),
      .ibus_rdt  (ibus.rdt),
      .ibus_ack  (ibus.ack),
      .i_phase   (phase),
      .i_cnt     (cnt),
      .o_dec     (dec),
      .o_imm_bit (imm_bit)
   );

   core_alu alu (
      .clk       (clk),
      .i_dec     (dec),
      .i_cnt     (cnt),
      .i_rs1_bit (rs1_bit),
      .i_rs2_bit (rs2_bit),
      .i_imm_bit (imm_bit),
      .o_rd_bit  (alu_bit)
   );

   core_regfile regfile (
      .clk       (clk),
      .i_dec     (dec),
      .i_cnt     (cnt),
      .i_rd_wen  (rd_wen),
      .i_alu_bit (alu_bit),
      .i_mem_bit (mem_bit),
      .i_imm_bit (imm_bit),
      .o_rs1_bit (rs1_bit),
      .o_rs2_bit (rs2_bit)
   );

   core_lsu lsu (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_dec      (dec),
      .i_phase    (phase),
      .i_cnt      (cnt),
      .i_rs1_bit  (rs1_bit),
      .i_rs2_bit  (rs2_bit),
      .i_imm_bit  (imm_bit),
      .o_mem_bit  (mem_bit),
      .o_mem_done (mem_done),
      .dbus       (dbus.requester)
   );

   mem_arbiter arbiter (
      .ibus      (ibus.arbiter),
      .dbus      (dbus.arbiter),
      .o_mem_adr (o_mem_adr),
      .o_mem_dat (o_mem_dat),
      .o_mem_we  (o_mem_we),
      .o_mem_cyc (o_mem_cyc),
      .i_mem_rdt (i_mem_rdt),
      .i_mem_ack (i_mem_ack)
   );

endmodule

// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f flist.f --top-module tb_core -o tb_core; then
   echo "Verilator build failed"
   exit 1
fi

if ! out=$(./obj_dir/tb_core); then
   echo "$out"
   echo "Simulation exited with an error"
   exit 1
fi
echo "$out"

if echo "$out" | grep -qx "Done: no errors"; then
   exit 0
fi
exit 1

// File: include/tb_program.svh
// Test program for the core testbench with the expected data accesses
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam word_t DATA_BASE   = 32'h0000_0100;
localparam int    STORE_COUNT = 13;

// Columns are instruction, access kind, expected address, expected store data
task automatic build_program();
   // addi x1,x0,0x100 / addi x2,x0,5 / addi x3,x0,-3
   add_step(32'h1000_0093, STEP_PLAIN, '0, '0);
   add_step(32'h0050_0113, STEP_PLAIN, '0, '0);
   add_step(32'hFFD0_0193, STEP_PLAIN, '0, '0);
   // add x4,x2,x3 / sw x4,0(x1)
   add_step(32'h0031_0233, STEP_PLAIN, '0, '0);
   add_step(32'h0040_A023, STEP_STORE, 32'h0000_0100, 32'h0000_0002);
   // sub x5,x3,x2 / sw x5,4(x1)
   add_step(32'h4021_82B3, STEP_PLAIN, '0, '0);
   add_step(32'h0050_A223, STEP_STORE, 32'h0000_0104, 32'hFFFF_FFF8);
   // Wraparound with lui x6,0x80000 / addi x7,x6,-1 / sw x7,8(x1)
   add_step(32'h8000_0337, STEP_PLAIN, '0, '0);
   add_step(32'hFFF3_0393, STEP_PLAIN, '0, '0);
   add_step(32'h0070_A423, STEP_STORE, 32'h0000_0108, 32'h7FFF_FFFF);
   // Full constant from lui x8,0x12345 / addi x8,x8,0x678 / sw x8,12(x1)
   add_step(32'h1234_5437, STEP_PLAIN, '0, '0);
   add_step(32'h6784_0413, STEP_PLAIN, '0, '0);
   add_step(32'h0080_A623, STEP_STORE, 32'h0000_010C, 32'h1234_5678);
   // andi x9,x8,-16 / sw x9,16(x1)
   add_step(32'hFF04_7493, STEP_PLAIN, '0, '0);
   add_step(32'h0090_A823, STEP_STORE, 32'h0000_0110, 32'h1234_5670);
   // ori x10,x2,0x7a0 / xori x11,x8,-1
   add_step(32'h7A01_6513, STEP_PLAIN, '0, '0);
   add_step(32'hFFF4_4593, STEP_PLAIN, '0, '0);
   // and x12,x8,x10 / or x13,x10,x6 / xor x14,x8,x11
   add_step(32'h00A4_7633, STEP_PLAIN, '0, '0);
   add_step(32'h0065_66B3, STEP_PLAIN, '0, '0);
   add_step(32'h00B4_4733, STEP_PLAIN, '0, '0);
   // sw x10..x14 at 20(x1) through 36(x1)
   add_step(32'h00A0_AA23, STEP_STORE, 32'h0000_0114, 32'h0000_07A5);
   add_step(32'h00B0_AC23, STEP_STORE, 32'h0000_0118, 32'hEDCB_A987);
   add_step(32'h00C0_AE23, STEP_STORE, 32'h0000_011C, 32'h0000_0620);
   add_step(32'h02D0_A023, STEP_STORE, 32'h0000_0120, 32'h8000_07A5);
   add_step(32'h02E0_A223, STEP_STORE, 32'h0000_0124, 32'hFFFF_FFFF);
   // addi x0,x0,0x55 must not stick / sw x0,40(x1)
   add_step(32'h0550_0013, STEP_PLAIN, '0, '0);
   add_step(32'h0200_A423, STEP_STORE, 32'h0000_0128, 32'h0000_0000);
   // Reload of an earlier store by lw x15,4(x1) / sw x15,44(x1)
   add_step(32'h0040_A783, STEP_LOAD,  32'h0000_0104, '0);
   add_step(32'h02F0_A623, STEP_STORE, 32'h0000_012C, 32'hFFFF_FFF8);
   // Untouched word keeps its fill through lw x16,60(x1) / sw x16,48(x1)
   add_step(32'h03C0_A803, STEP_LOAD,  32'h0000_013C, '0);
   add_step(32'h0300_A823, STEP_STORE, 32'h0000_0130, 32'hA5A5_A499);
endtask

`endif

// File: sim/tb_core.sv
// Testbench for the bit-serial core with memory model, program table loop and checks
`timescale 1ns/1ns

module tb_core;
   import core_pkg::*;

   localparam word_t RESET_PC = 32'h0000_0200;

   typedef enum {STEP_PLAIN, STEP_LOAD, STEP_STORE} step_kind_e;

   typedef struct {
      word_t      insn;
      step_kind_e kind;
      word_t      adr;
      word_t      dat;
   } step_t;

   logic   clk;
   logic   i_reset;
   word_t  i_mem_rdt;
   logic   i_mem_ack;
   word_t  o_mem_adr;
   word_t  o_mem_dat;
   logic   o_mem_we;
   logic   o_mem_cyc;

   step_t  steps[$];
   word_t  data_mem [16];
   integer seed;
   int     store_cnt;

   `include "tb_program.svh"

   serial_core_top #(.RESET_PC(RESET_PC)) dut (
      .clk       (clk),
      .i_reset   (i_reset),
      .o_mem_adr (o_mem_adr),
      .o_mem_dat (o_mem_dat),
      .o_mem_we  (o_mem_we),
      .o_mem_cyc (o_mem_cyc),
      .i_mem_rdt (i_mem_rdt),
      .i_mem_ack (i_mem_ack)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic add_step(word_t insn, step_kind_e kind, word_t adr, word_t dat);
      steps.push_back('{insn, kind, adr, dat});
   endtask

   task automatic abort_run();
      $display("Done: errors found");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_word(string name, word_t got, word_t exp);
      if (got !== exp) begin
         $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_bit(string name, logic got, logic exp);
      if (got !== exp) begin
         $display("FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_count(string name, int got, int exp);
      if (got != exp) begin
         $display("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
         abort_run();
      end
   endtask

   // Returns at the falling edge where a request is seen
   task automatic wait_request(output word_t adr, output logic we, output word_t dat);
      do begin
         @(negedge clk);
      end while (!o_mem_cyc);
      adr = o_mem_adr;
      we  = o_mem_we;
      dat = o_mem_dat;
   endtask

   // Random wait of 0 to 3 cycles, then a one-cycle ack
   task automatic ack_request(word_t rdt);
      int delay;
      delay = $unsigned($random(seed)) % 4;
      repeat (delay) @(negedge clk);
      // Only a store still on the bus is taken by the memory
      if (o_mem_cyc && o_mem_we) begin
         store_cnt++;
      end
      i_mem_rdt = rdt;
      i_mem_ack = 1'b1;
      @(negedge clk);
      i_mem_ack = 1'b0;
   endtask

   initial begin
      int    cycles;
      int    cycle_limit;
      @(negedge i_reset);
      cycle_limit = steps.size() * 120;
      cycles = 0;
      while (cycles < cycle_limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: the program did not finish within %0d clock cycles", cycles);
      abort_run();
   end

   initial begin
      word_t adr;
      logic  we;
      word_t dat;
      i_reset   = 1'b1;
      i_mem_rdt = '0;
      i_mem_ack = 1'b0;
      seed      = 32'h8fcb946b;
      store_cnt = 0;
      build_program();
      for (int a = 0; a < 16; a++) begin
         data_mem[a] = (DATA_BASE + 32'(4 * a)) ^ 32'hA5A5_A5A5;
      end
      repeat (3) @(negedge clk);
      i_reset = 1'b0;
      check_bit("o_mem_cyc", o_mem_cyc, 1'b0);
      check_bit("o_mem_we", o_mem_we, 1'b0);

      for (int i = 0; i < steps.size(); i++) begin
         wait_request(adr, we, dat);
         check_word("o_mem_adr", adr, RESET_PC + 32'(4 * i));
         check_bit("o_mem_we", we, 1'b0);
         ack_request(steps[i].insn);
         if (steps[i].kind != STEP_PLAIN) begin
            wait_request(adr, we, dat);
            check_word("o_mem_adr", adr, steps[i].adr);
            check_bit("o_mem_we", we, steps[i].kind == STEP_STORE);
            if (steps[i].kind == STEP_STORE) begin
               check_word("o_mem_dat", dat, steps[i].dat);
               data_mem[adr[5:2]] = dat;
               ack_request('0);
            end else begin
               ack_request(data_mem[adr[5:2]]);
            end
         end
      end

      check_count("store count", store_cnt, STORE_COUNT);
      $display("Done: no errors");
      $finish;
   end

endmodule
